// File: rtl/core_pkg.sv
package core_pkg;

  // data word, also used for instruction addresses
  typedef logic [31:0] word_t;
  // architectural register index, x0..x31
  typedef logic [4:0] reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLT     = 3'b010,
    F3_XOR     = 3'b100,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } alu_funct3_e;

  // funct3 of BRANCH
  typedef enum logic [2:0] {
    F3_BEQ = 3'b000,
    F3_BNE = 3'b001
  } br_funct3_e;

  // funct7 of OP, ALT selects sub
  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_ALT  = 7'b0100000
  } funct7_e;

  // alu operation, pass_b carries the lui immediate
  typedef enum logic [2:0] {
    ALU_NONE,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // control flow kind
  typedef enum logic [1:0] {
    PC_NONE,
    PC_BEQ,
    PC_BNE,
    PC_JAL
  } pc_op_e;

  // addi x0, x0, 0
  localparam word_t inst_nop = 32'h0000_0013;

  // decoded instruction, held in ID/EX
  typedef struct packed {
    logic     valid;
    word_t    inst_addr;
    word_t    inst_data;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    reg_idx_t rd_idx;
    logic     rd_wen;
    word_t    imm;
    logic     use_imm;
    word_t    rs1_data;
    word_t    rs2_data;
    alu_op_e  alu_op;
    pc_op_e   pc_op;
    logic     bpu_taken;
    logic     illegal;
  } id_ex_t;

  // write-back result
  typedef struct packed {
    logic     valid;
    reg_idx_t rd_idx;
    logic     rd_wen;
    word_t    data;
    logic     illegal;
  } wb_t;

endpackage

// File: rtl/reg_file.sv
module reg_file
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  reg_idx_t rs1_idx_i,
  input  reg_idx_t rs2_idx_i,
  input  wb_t      wb_i,
  output word_t    rs1_data_o,
  output word_t    rs2_data_o
);

  // x0 has no storage
  word_t regs [1:31];
  logic  wr_en;

  // only real writes to a nonzero register
  assign wr_en = wb_i.valid && wb_i.rd_wen && (wb_i.rd_idx != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_i.rd_idx] <= wb_i.data;
    end
  end

  // read with write-through, same-cycle write wins
  function automatic word_t read_port(reg_idx_t idx);
    word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (wr_en && (wb_i.rd_idx == idx)) begin
      val = wb_i.data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  assign rs1_data_o = read_port(rs1_idx_i);
  assign rs2_data_o = read_port(rs2_idx_i);

endmodule

// File: rtl/decode_stage.sv
module decode_stage
  import core_pkg::*;
(
  input  logic     inst_valid_i,
  input  word_t    inst_addr_i,
  input  word_t    inst_data_i,
  input  logic     bpu_taken_i,
  input  word_t    rs1_data_i,
  input  word_t    rs2_data_i,
  output reg_idx_t rs1_idx_o,
  output reg_idx_t rs2_idx_o,
  output id_ex_t   id_ex_o
);

  // instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;

  // immediates per format
  word_t imm_i;
  word_t imm_u;
  word_t imm_b;
  word_t imm_j;

  // decode results
  alu_op_e alu_op;
  pc_op_e  pc_op;
  word_t   imm;
  logic    use_imm;
  logic    wen;
  logic    legal;

  assign opcode = inst_data_i[6:0];
  assign rd     = inst_data_i[11:7];
  assign funct3 = inst_data_i[14:12];
  assign rs1    = inst_data_i[19:15];
  assign rs2    = inst_data_i[24:20];
  assign funct7 = inst_data_i[31:25];

  // sign extended, b and j are in halfwords
  assign imm_i = {{20{inst_data_i[31]}}, inst_data_i[31:20]};
  assign imm_u = {inst_data_i[31:12], 12'b0};
  assign imm_b = {{19{inst_data_i[31]}}, inst_data_i[31], inst_data_i[7],
                  inst_data_i[30:25], inst_data_i[11:8], 1'b0};
  assign imm_j = {{11{inst_data_i[31]}}, inst_data_i[31], inst_data_i[19:12],
                  inst_data_i[20], inst_data_i[30:21], 1'b0};

  always_comb begin
    alu_op  = ALU_NONE;
    pc_op   = PC_NONE;
    imm     = '0;
    use_imm = 1'b0;
    wen     = 1'b0;
    legal   = 1'b0;
    case (opcode)
      OPC_OP: begin
        // only funct7 base, except sub
        case (funct3)
          F3_ADD_SUB: begin
            if (funct7 == F7_BASE) begin
              alu_op = ALU_ADD;
            end else if (funct7 == F7_ALT) begin
              alu_op = ALU_SUB;
            end
          end
          F3_SLT: if (funct7 == F7_BASE) alu_op = ALU_SLT;
          F3_XOR: if (funct7 == F7_BASE) alu_op = ALU_XOR;
          F3_OR:  if (funct7 == F7_BASE) alu_op = ALU_OR;
          F3_AND: if (funct7 == F7_BASE) alu_op = ALU_AND;
          default: ;
        endcase
        legal = (alu_op != ALU_NONE);
        wen   = legal;
      end
      OPC_OP_IMM: begin
        // addi only
        if (funct3 == F3_ADD_SUB) begin
          alu_op  = ALU_ADD;
          imm     = imm_i;
          use_imm = 1'b1;
          wen     = 1'b1;
          legal   = 1'b1;
        end
      end
      OPC_LUI: begin
        alu_op  = ALU_PASS_B;
        imm     = imm_u;
        use_imm = 1'b1;
        wen     = 1'b1;
        legal   = 1'b1;
      end
      OPC_BRANCH: begin
        // compare happens in execute on rs1/rs2
        imm = imm_b;
        if (funct3 == F3_BEQ) begin
          pc_op = PC_BEQ;
          legal = 1'b1;
        end else if (funct3 == F3_BNE) begin
          pc_op = PC_BNE;
          legal = 1'b1;
        end
      end
      OPC_JAL: begin
        // link value built in execute
        pc_op = PC_JAL;
        imm   = imm_j;
        wen   = 1'b1;
        legal = 1'b1;
      end
      default: ;
    endcase
  end

  assign rs1_idx_o = rs1;
  assign rs2_idx_o = rs2;

  always_comb begin
    id_ex_o.valid     = inst_valid_i;
    id_ex_o.inst_addr = inst_addr_i;
    id_ex_o.inst_data = inst_data_i;
    id_ex_o.rs1_idx   = rs1;
    id_ex_o.rs2_idx   = rs2;
    id_ex_o.rd_idx    = rd;
    // x0 writes dropped here already
    id_ex_o.rd_wen    = wen && (rd != '0);
    id_ex_o.imm       = imm;
    id_ex_o.use_imm   = use_imm;
    id_ex_o.rs1_data  = rs1_data_i;
    id_ex_o.rs2_data  = rs2_data_i;
    id_ex_o.alu_op    = alu_op;
    id_ex_o.pc_op     = pc_op;
    id_ex_o.bpu_taken = bpu_taken_i;
    id_ex_o.illegal   = inst_valid_i && !legal;
  end

endmodule

// File: rtl/id_ex_reg.sv
module id_ex_reg
  import core_pkg::*;
(
  input  logic   clk,
  input  logic   rst_i,
  input  logic   stall_i,
  input  logic   flush_i,
  input  id_ex_t id_ex_i,
  output id_ex_t id_ex_o
);

  // empty slot, nop encoding with nothing enabled
  localparam id_ex_t id_ex_nop = '{
    valid:     1'b0,
    inst_addr: '0,
    inst_data: inst_nop,
    rs1_idx:   '0,
    rs2_idx:   '0,
    rd_idx:    '0,
    rd_wen:    1'b0,
    imm:       '0,
    use_imm:   1'b0,
    rs1_data:  '0,
    rs2_data:  '0,
    alu_op:    ALU_NONE,
    pc_op:     PC_NONE,
    bpu_taken: 1'b0,
    illegal:   1'b0
  };

  id_ex_t id_ex_q;

  // flush before stall, younger slot is killed even when held
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      id_ex_q <= id_ex_nop;
    end else if (!stall_i) begin
      id_ex_q <= id_ex_i;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

// File: rtl/exec_stage.sv
module exec_stage
  import core_pkg::*;
(
  input  logic   clk,
  input  logic   rst_i,
  input  logic   stall_i,
  input  id_ex_t id_ex_i,
  output wb_t    wb_o,
  output logic   redirect_valid_o,
  output word_t  redirect_addr_o
);

  wb_t   wb_q;
  wb_t   wb_d;
  logic  fwd_a;
  logic  fwd_b;
  word_t op_a;
  word_t rs2_val;
  word_t op_b;
  word_t alu_res;
  word_t link_addr;
  word_t target_addr;
  logic  rs_eq;
  logic  taken;

  // forward from the result register
  // rd_wen already excludes x0, payload survives a stall bubble
  assign fwd_a = wb_q.rd_wen && (wb_q.rd_idx == id_ex_i.rs1_idx);
  assign fwd_b = wb_q.rd_wen && (wb_q.rd_idx == id_ex_i.rs2_idx);

  assign op_a    = fwd_a ? wb_q.data : id_ex_i.rs1_data;
  assign rs2_val = fwd_b ? wb_q.data : id_ex_i.rs2_data;
  assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // branch resolution
  assign link_addr   = id_ex_i.inst_addr + 32'd4;
  assign target_addr = id_ex_i.inst_addr + id_ex_i.imm;
  assign rs_eq       = (op_a == rs2_val);

  always_comb begin
    case (id_ex_i.pc_op)
      PC_BEQ:  taken = rs_eq;
      PC_BNE:  taken = !rs_eq;
      PC_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // mispredict, raised once when the instruction leaves execute
  // a held branch waits so the flush never hits itself
  assign redirect_valid_o = id_ex_i.valid && !stall_i && (taken != id_ex_i.bpu_taken);
  assign redirect_addr_o  = taken ? target_addr : link_addr;

  always_comb begin
    wb_d.valid   = id_ex_i.valid;
    wb_d.rd_idx  = id_ex_i.rd_idx;
    wb_d.rd_wen  = id_ex_i.valid && id_ex_i.rd_wen;
    // jal links pc+4
    wb_d.data    = (id_ex_i.pc_op == PC_JAL) ? link_addr : alu_res;
    wb_d.illegal = id_ex_i.illegal;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_q <= '0;
    end else if (stall_i) begin
      // bubble, held instruction retires after the stall
      wb_q.valid <= 1'b0;
    end else begin
      wb_q <= wb_d;
    end
  end

  assign wb_o = wb_q;

endmodule

// File: rtl/int_pipe_top.sv
module int_pipe_top
  import core_pkg::*;
(
  input  logic  clk,
  input  logic  rst_i,
  input  logic  inst_valid_i,
  input  word_t inst_addr_i,
  input  word_t inst_data_i,
  input  logic  bpu_taken_i,
  input  logic  stall_i,
  output wb_t   wb_o,
  output logic  redirect_valid_o,
  output word_t redirect_addr_o
);

  // register file read ports
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  word_t    rs1_data;
  word_t    rs2_data;

  // decode to execute
  id_ex_t id_ex_d;
  id_ex_t id_ex_q;

  // write port fed by the result register
  reg_file u_reg_file (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wb_i       (wb_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  decode_stage u_decode_stage (
    .inst_valid_i (inst_valid_i),
    .inst_addr_i  (inst_addr_i),
    .inst_data_i  (inst_data_i),
    .bpu_taken_i  (bpu_taken_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .id_ex_o      (id_ex_d)
  );

  // redirect squashes the younger slot
  id_ex_reg u_id_ex_reg (
    .clk     (clk),
    .rst_i   (rst_i),
    .stall_i (stall_i),
    .flush_i (redirect_valid_o),
    .id_ex_i (id_ex_d),
    .id_ex_o (id_ex_q)
  );

  exec_stage u_exec_stage (
    .clk              (clk),
    .rst_i            (rst_i),
    .stall_i          (stall_i),
    .id_ex_i          (id_ex_q),
    .wb_o             (wb_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_addr_o  (redirect_addr_o)
  );

endmodule

// File: sim/int_pipe_tb.sv
module int_pipe_tb
  import core_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam stim_path = "sim/int_pipe_stim.txt";

  // one presented instruction and its control bits
  typedef struct packed {
    word_t addr;
    word_t data;
    logic  taken;
    logic  stall;
  } stim_inst_t;

  // expected register write
  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
  } exp_wb_t;

  localparam stim_inst_t idle_inst = {32'h0, inst_nop, 1'b0, 1'b0};

  logic  clk;
  logic  rst;
  logic  inst_valid;
  word_t inst_addr;
  word_t inst_data;
  logic  bpu_taken;
  logic  stall;
  wb_t   wb;
  logic  redirect_valid;
  word_t redirect_addr;

  stim_inst_t inst_q[$];
  exp_wb_t    wb_exp_q[$];
  word_t      redir_exp_q[$];
  // illegal flag of each instruction still in flight, oldest first
  logic       ill_exp_q[$];
  int         line_cnt = 0;
  int         cycle_cnt = 0;
  int         cycle_limit = 0;

  int_pipe_top dut0 (
    .clk              (clk),
    .rst_i            (rst),
    .inst_valid_i     (inst_valid),
    .inst_addr_i      (inst_addr),
    .inst_data_i      (inst_data),
    .bpu_taken_i      (bpu_taken),
    .stall_i          (stall),
    .wb_o             (wb),
    .redirect_valid_o (redirect_valid),
    .redirect_addr_o  (redirect_addr)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // rv32i encodings of the supported subset
  function automatic logic is_unsupported(input word_t inst);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    opc = inst[6:0];
    f3  = inst[14:12];
    f7  = inst[31:25];
    case (opc)
      // add, slt, xor, or, and, sub
      7'h33: ok = (f7 == 7'h00 && (f3 == 3'd0 || f3 == 3'd2 || f3 == 3'd4 ||
                                    f3 == 3'd6 || f3 == 3'd7)) ||
                  (f7 == 7'h20 && f3 == 3'd0);
      // addi
      7'h13: ok = (f3 == 3'd0);
      // lui
      7'h37: ok = 1'b1;
      // beq, bne
      7'h63: ok = (f3 == 3'd0 || f3 == 3'd1);
      // jal
      7'h6f: ok = 1'b1;
      default: ok = 1'b0;
    endcase
    return !ok;
  endfunction

  // limit grows with the stimulus length
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles, the run did not finish", cycle_cnt));
    end
  end

  // whole file into queues before reset ends
  task automatic read_stim();
    int    fd;
    int    code;
    int    want;
    byte   kind;
    string line;
    word_t f_addr;
    word_t f_data;
    int    f_rd;
    int    f_taken;
    int    f_stall;
    stim_inst_t inst;
    exp_wb_t    exp;
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      fail_run($sformatf("Could not open the stimulus file %s", stim_path));
    end else begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        case (kind)
          "#": begin
            code = $fgets(line, fd);
            want = code;
          end
          "I": begin
            code = $fscanf(fd, "%h %h %d %d", f_addr, f_data, f_taken, f_stall);
            want = 4;
            inst.addr  = f_addr;
            inst.data  = f_data;
            inst.taken = f_taken[0];
            inst.stall = f_stall[0];
            inst_q.push_back(inst);
            line_cnt++;
          end
          "W": begin
            code = $fscanf(fd, "%d %h", f_rd, f_data);
            want = 2;
            exp.rd   = f_rd[4:0];
            exp.data = f_data;
            wb_exp_q.push_back(exp);
            line_cnt++;
          end
          "R": begin
            code = $fscanf(fd, "%h", f_addr);
            want = 1;
            redir_exp_q.push_back(f_addr);
            line_cnt++;
          end
          default: begin
            code = 0;
            want = 1;
          end
        endcase
        if (code != want) begin
          fail_run($sformatf("Bad line of kind %c in the stimulus file", kind));
        end
      end
      $fclose(fd);
    end
  endtask

  // only real register writes are compared against the data file
  task automatic check_outputs();
    exp_wb_t exp;
    word_t   exp_addr;
    logic    exp_ill;
    if (wb.valid && wb.rd_wen) begin
      if (wb_exp_q.size() == 0) begin
        fail_run($sformatf("Unexpected write to x%0d at %0t ns", wb.rd_idx, $time));
      end else begin
        exp = wb_exp_q.pop_front();
        check_value("write-back index", {27'b0, wb.rd_idx}, {27'b0, exp.rd});
        check_value("write-back data", wb.data, exp.data);
      end
    end
    // every retirement, writing or not, in program order
    if (wb.valid) begin
      if (ill_exp_q.size() == 0) begin
        fail_run($sformatf("Unexpected retirement at %0t ns", $time));
      end else begin
        exp_ill = ill_exp_q.pop_front();
        check_value("illegal flag", {31'b0, wb.illegal}, {31'b0, exp_ill});
      end
    end
    if (redirect_valid) begin
      if (redir_exp_q.size() == 0) begin
        fail_run($sformatf("Unexpected redirect to %h at %0t ns", redirect_addr, $time));
      end else begin
        exp_addr = redir_exp_q.pop_front();
        check_value("redirect address", redirect_addr, exp_addr);
      end
    end
    // enters ID/EX on the coming edge unless held or squashed
    if (inst_valid && !stall && !redirect_valid) begin
      ill_exp_q.push_back(is_unsupported(inst_data));
    end
  endtask

  // drive on the falling edge, look just before the rising one
  task automatic step_cycle(input logic valid, input stim_inst_t inst);
    @(negedge clk);
    inst_valid = valid;
    inst_addr  = inst.addr;
    inst_data  = inst.data;
    bpu_taken  = inst.taken;
    stall      = inst.stall;
    #45;
    check_outputs();
  endtask

  initial begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst_addr  = '0;
    inst_data  = inst_nop;
    bpu_taken  = 1'b0;
    stall      = 1'b0;
    read_stim();
    cycle_limit = line_cnt * 4 + 20;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // quiet pipe after reset
    repeat (2) begin
      step_cycle(1'b0, idle_inst);
      check_value("write-back valid after reset", {31'b0, wb.valid}, '0);
      check_value("redirect valid after reset", {31'b0, redirect_valid}, '0);
    end
    for (int i = 0; i < inst_q.size(); i++) begin
      step_cycle(1'b1, inst_q[i]);
    end
    // two cycle latency, then some slack
    repeat (4) step_cycle(1'b0, idle_inst);
    if (wb_exp_q.size() != 0 || redir_exp_q.size() != 0 || ill_exp_q.size() != 0) begin
      fail_run($sformatf("%0d writes, %0d redirects and %0d retirements never came",
                         wb_exp_q.size(), redir_exp_q.size(), ill_exp_q.size()));
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: sim/int_pipe_stim.txt
# I <addr> <inst> <taken> <stall> | W <rd> <data> | R <redirect addr>
# addr, inst, data in hex; rd, taken, stall in decimal
I 00000100 00500093 0 0
W 1 00000005
I 00000104 ffd08113 0 0
W 2 00000002
I 00000108 002081b3 0 0
W 3 00000007
I 0000010c 40310233 0 0
W 4 fffffffb
I 00000110 001272b3 0 0
W 5 00000001
I 00000114 0022e333 0 0
W 6 00000003
I 00000118 004343b3 0 0
W 7 fffffff8
I 0000011c 00122433 0 0
W 8 00000001
I 00000120 abcde4b7 0 0
W 9 abcde000
I 00000124 00208033 0 0
I 00000128 00900533 0 0
W 10 abcde000
I 0000012c 00150593 0 0
W 11 abcde001
I 00000130 00b58633 0 1
I 00000130 00b58633 0 1
I 00000130 00b58633 0 0
W 12 579bc002
I 00000134 00508863 0 0
I 00000138 06400713 0 0
W 14 00000064
I 0000013c 00171663 1 0
I 00000148 fff70793 0 0
W 15 00000063
I 0000014c 02f78063 0 0
R 0000016c
I 00000150 00700813 0 0
I 0000016c 00109863 1 0
R 00000170
I 0000017c 00700813 0 0
I 00000170 040008ef 0 0
R 000001b0
W 17 00000174
I 00000174 00700813 0 0
I 000001b0 fe0716e3 0 0
R 0000019c
I 000001b4 00700813 0 0
I 0000019c 001090b3 0 0
I 000001a0 ffffffff 0 0
I 000001a4 00008933 0 0
W 18 00000005
I 000001a8 00888993 0 0
W 19 0000017c

// File: flist.f
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/id_ex_reg.sv
rtl/exec_stage.sv
rtl/int_pipe_top.sv
sim/int_pipe_tb.sv

// File: Bender.yml
package:
  name: int_pipe

sources:
  - rtl/core_pkg.sv
  - rtl/reg_file.sv
  - rtl/decode_stage.sv
  - rtl/id_ex_reg.sv
  - rtl/exec_stage.sv
  - rtl/int_pipe_top.sv
  - target: simulation
    files:
      - sim/int_pipe_tb.sv
